/* compile.f */
verilog/csc_pkg.sv
verilog/sram_sequencer.sv
verilog/chroma_upsampler.sv
verilog/colour_matrix.sv
verilog/yuv_to_rgb_top.sv
tb/csc_assertions.sv
tb/csc_checker.sv
tb/tb_top.sv

/* tb/csc_assertions.sv */
`timescale 1ns/1ps

module csc_assertions (
	input logic                Clock_50,
	input logic                Resetn,
	input logic                start,
	input csc_pkg::sram_req_t  sram_req,
	input logic                done
);

int fail_count = 0;

// results only land in the RGB region
write_in_rgb_region: assert property (@(posedge Clock_50) disable iff (!Resetn)
	!sram_req.we_n |-> sram_req.address >= csc_pkg::rgb_base)
	else begin
		fail_count++;
		$error("write at address %0d below the RGB region", sram_req.address);
	end

// source reads stay below the RGB region
read_below_rgb_region: assert property (@(posedge Clock_50) disable iff (!Resetn)
	sram_req.we_n |-> sram_req.address < csc_pkg::rgb_base)
	else begin
		fail_count++;
		$error("read at address %0d inside the RGB region", sram_req.address);
	end

no_write_when_done: assert property (@(posedge Clock_50) disable iff (!Resetn)
	done |-> sram_req.we_n)
	else begin
		fail_count++;
		$error("SRAM write while done is high");
	end

start_clears_done: assert property (@(posedge Clock_50) disable iff (!Resetn)
	start |=> !done)
	else begin
		fail_count++;
		$error("done still high in the cycle after start");
	end

endmodule

/* tb/csc_checker.sv */
`timescale 1ns/1ps

module csc_checker (
	input logic               Clock_50,
	input logic               Resetn,
	input logic               start,
	input csc_pkg::sram_req_t sram_req,
	input logic               done
);

// source image of the current row
csc_pkg::sample_t y_img [0:csc_pkg::row_pixels - 1];
csc_pkg::sample_t u_img [0:csc_pkg::row_pairs - 1];
csc_pkg::sample_t v_img [0:csc_pkg::row_pairs - 1];
string row_name = "idle";
int value_errors = 0;
int flow_errors = 0;
int rows_checked = 0;
int write_count = 0;
bit written [0:csc_pkg::rgb_words - 1];
bit row_open = 1'b0;
bit done_seen = 1'b0;
bit start_seen = 1'b0;

function automatic int clip_byte(input int value, input int shift);
	int scaled;
	if (value < 0) return 0;
	scaled = value >> shift;
	return (scaled > 255) ? 255 : scaled;
endfunction

// out of range indices replicate the edge sample
function automatic int chroma_at(input bit is_u, input int idx);
	int k;
	k = (idx < 0) ? 0 : ((idx >= csc_pkg::row_pairs) ? csc_pkg::row_pairs - 1 : idx);
	return is_u ? int'(u_img[k]) : int'(v_img[k]);
endfunction

function automatic int odd_chroma(input bit is_u, input int k);
	int acc;
	acc = csc_pkg::tap_outer * (chroma_at(is_u, k - 2) + chroma_at(is_u, k + 3))
		- csc_pkg::tap_mid * (chroma_at(is_u, k - 1) + chroma_at(is_u, k + 2))
		+ csc_pkg::tap_inner * (chroma_at(is_u, k) + chroma_at(is_u, k + 1))
		+ csc_pkg::fir_round;
	return clip_byte(acc, csc_pkg::fir_shift);
endfunction

// {r, g, b} for one pixel
function automatic logic [23:0] model_rgb(input int y, input int u, input int v);
	int ys;
	int us;
	int vs;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	ys = y - csc_pkg::y_offset;
	us = u - csc_pkg::c_offset;
	vs = v - csc_pkg::c_offset;
	r = 8'(clip_byte(csc_pkg::k_y * ys + csc_pkg::k_rv * vs, csc_pkg::mat_shift));
	g = 8'(clip_byte(csc_pkg::k_y * ys - csc_pkg::k_gu * us - csc_pkg::k_gv * vs,
		csc_pkg::mat_shift));
	b = 8'(clip_byte(csc_pkg::k_y * ys + csc_pkg::k_bu * us, csc_pkg::mat_shift));
	return {r, g, b};
endfunction

function automatic logic [15:0] expected_word(input int idx);
	int k;
	logic [23:0] even_rgb;
	logic [23:0] odd_rgb;
	k = idx / 3;
	even_rgb = model_rgb(y_img[2 * k], u_img[k], v_img[k]);
	odd_rgb = model_rgb(y_img[2 * k + 1], odd_chroma(1'b1, k), odd_chroma(1'b0, k));
	case (idx % 3)
		0: return even_rgb[23:8];
		1: return {even_rgb[7:0], odd_rgb[23:16]};
		default: return odd_rgb[15:0];
	endcase
endfunction

always @(posedge Clock_50) begin
	int idx;
	logic [15:0] expected;
	if (!Resetn) begin
		row_open = 1'b0;
		done_seen = 1'b0;
		start_seen = 1'b0;
	end else begin
		if (!sram_req.we_n) begin
			idx = int'(sram_req.address) - int'(csc_pkg::rgb_base);
			if (!row_open) begin
				flow_errors++;
				$display("write at address %0d while no row was running", sram_req.address);
			end else if (idx < 0 || idx >= csc_pkg::rgb_words) begin
				flow_errors++;
				$display("%s: write at address %0d is outside the row", row_name,
					sram_req.address);
			end else if (written[idx]) begin
				flow_errors++;
				$display("%s: RGB word %0d was written twice", row_name, idx);
			end else begin
				written[idx] = 1'b1;
				write_count++;
				expected = expected_word(idx);
				if (sram_req.write_data !== expected) begin
					value_errors++;
					$display("FAILED %s word %0d: expected %h, actual %h", row_name, idx,
						expected, sram_req.write_data);
				end
			end
		end
		if (done && !done_seen) begin
			if (!row_open) begin
				flow_errors++;
				$display("done went high although no row was started");
			end else begin
				if (write_count != csc_pkg::rgb_words) begin
					value_errors++;
					$display("FAILED %s write count: expected %0d, actual %0d", row_name,
						csc_pkg::rgb_words, write_count);
				end
				rows_checked++;
				row_open = 1'b0;
			end
		end
		// done must hold until a new start clears it
		if (done_seen && !done && !start_seen) begin
			flow_errors++;
			$display("%s: done went low without a new start", row_name);
		end
		done_seen = done;
		start_seen = start;
		if (start && !row_open) begin
			row_open = 1'b1;
			write_count = 0;
			for (int i = 0; i < csc_pkg::rgb_words; i++) begin
				written[i] = 1'b0;
			end
		end
	end
end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

localparam int clock_period = 10;
localparam int row_count = 4;
// each row gets eight cycles per pair plus slack for lead-in and drain
localparam int watchdog_cycles = row_count * (8 * csc_pkg::row_pairs + 200);

logic Clock_50;
logic Resetn;
logic start;
csc_pkg::sram_word_t sram_read_data = '0;
csc_pkg::sram_req_t sram_req;
logic done;
csc_pkg::sram_word_t sram_mem [0:(1 << 18) - 1];
csc_pkg::sram_word_t read_stage = '0;
int missing_rows;
int total_errors;

yuv_to_rgb_top dut (
	.Clock_50       (Clock_50),
	.Resetn         (Resetn),
	.start          (start),
	.sram_read_data (sram_read_data),
	.sram_req       (sram_req),
	.done           (done)
);

csc_checker chk (
	.Clock_50 (Clock_50),
	.Resetn   (Resetn),
	.start    (start),
	.sram_req (sram_req),
	.done     (done)
);

bind yuv_to_rgb_top csc_assertions asrt (
	.Clock_50 (Clock_50),
	.Resetn   (Resetn),
	.start    (start),
	.sram_req (sram_req),
	.done     (done)
);

initial begin
	Clock_50 = 1'b0;
	forever #(clock_period / 2) Clock_50 = ~Clock_50;
end

// SRAM model with a two-cycle read latency
always @(posedge Clock_50) begin
	if (!sram_req.we_n) begin
		sram_mem[sram_req.address] = sram_req.write_data;
	end
	read_stage <= sram_mem[sram_req.address];
	sram_read_data <= read_stage;
end

function automatic csc_pkg::sample_t pick_luma(input int kind);
	case (kind)
		1: return 8'd255;
		2: return 8'd0;
		default: return 8'($urandom_range(255, 0));
	endcase
endfunction

// kind 1 alternates full scale and kind 2 picks random extremes
function automatic csc_pkg::sample_t pick_chroma(input int kind, input int idx, input bit is_u);
	case (kind)
		1: return (((idx % 2) == 1) ^ is_u) ? 8'd255 : 8'd0;
		2: return ($urandom_range(1, 0) == 1) ? 8'd255 : 8'd0;
		default: return 8'($urandom_range(255, 0));
	endcase
endfunction

task automatic load_row(input string name, input int kind);
	for (int i = 0; i < csc_pkg::row_pixels; i++) begin
		chk.y_img[i] = pick_luma(kind);
	end
	for (int i = 0; i < csc_pkg::row_pairs; i++) begin
		chk.u_img[i] = pick_chroma(kind, i, 1'b1);
		chk.v_img[i] = pick_chroma(kind, i, 1'b0);
	end
	// even sample in the high byte
	for (int i = 0; i < csc_pkg::row_pairs; i++) begin
		sram_mem[csc_pkg::y_base + i] = {chk.y_img[2 * i], chk.y_img[2 * i + 1]};
	end
	for (int i = 0; i < csc_pkg::chroma_words; i++) begin
		sram_mem[csc_pkg::u_base + i] = {chk.u_img[2 * i], chk.u_img[2 * i + 1]};
		sram_mem[csc_pkg::v_base + i] = {chk.v_img[2 * i], chk.v_img[2 * i + 1]};
	end
	chk.row_name = name;
endtask

task automatic run_row(input string name, input int kind);
	load_row(name, kind);
	@(posedge Clock_50);
	#1 start = 1'b1;
	@(posedge Clock_50);
	#1 start = 1'b0;
	do begin
		@(posedge Clock_50);
		#1;
	end while (!done);
	repeat (3) @(posedge Clock_50);
endtask

initial begin
	#(watchdog_cycles * clock_period);
	$display("timeout after %0d cycles, a row never finished", watchdog_cycles);
	$display("SOME TESTS FAILED");
	$finish;
end

initial begin
	start = 1'b0;
	Resetn = 1'b0;
	void'($urandom(67));
	repeat (5) @(posedge Clock_50);
	#1 Resetn = 1'b1;
	// idle stretch where no write may occur
	repeat (20) @(posedge Clock_50);
	run_row("random row 1", 0);
	run_row("random row 2", 0);
	run_row("bright extremes", 1);
	run_row("black row", 2);
	repeat (5) @(posedge Clock_50);
	missing_rows = row_count - chk.rows_checked;
	total_errors = chk.value_errors + chk.flow_errors + dut.asrt.fail_count + missing_rows;
	$display("errors: %0d value, %0d flow, %0d assertion, %0d rows not completed",
		chk.value_errors, chk.flow_errors, dut.asrt.fail_count, missing_rows);
	if (total_errors == 0) begin
		$display("ALL TESTS PASSED");
	end else begin
		$display("SOME TESTS FAILED");
	end
	$finish;
end

endmodule

/* verilog/chroma_upsampler.sv */
`timescale 1ns/1ps

module chroma_upsampler (
	input  logic                   Clock_50,
	input  logic                   Resetn,
	input  logic                   chroma_push,
	input  logic                   row_begin,
	input  csc_pkg::sample_t       u_sample,
	input  csc_pkg::sample_t       v_sample,
	input  csc_pkg::sample_t [1:0] y_pair,
	input  logic                   y_valid,
	output logic                   pair_valid,
	output csc_pkg::pixel_pair_t   pair
);

// slot 0 is the newest sample, slot 3 the centre of the pair
csc_pkg::sample_t [5:0] u_win;
csc_pkg::sample_t [5:0] v_win;
csc_pkg::sample_t [1:0] y_hold;

// symmetric six-tap interpolation with rounding and byte clip
function automatic csc_pkg::sample_t interpolate(input csc_pkg::sample_t [5:0] w);
	int acc;
	acc = csc_pkg::tap_outer * (int'(w[5]) + int'(w[0]))
		- csc_pkg::tap_mid * (int'(w[4]) + int'(w[1]))
		+ csc_pkg::tap_inner * (int'(w[3]) + int'(w[2]))
		+ csc_pkg::fir_round;
	acc = acc >>> csc_pkg::fir_shift;
	if (acc < 0) begin
		interpolate = 8'd0;
	end else if (acc > 255) begin
		interpolate = 8'd255;
	end else begin
		interpolate = acc[7:0];
	end
endfunction

always_ff @(posedge Clock_50) begin
	if (chroma_push) begin
		if (row_begin) begin
			// fill with the first sample for left edge replication
			u_win <= {6{u_sample}};
			v_win <= {6{v_sample}};
		end else begin
			u_win <= {u_win[4:0], u_sample};
			v_win <= {v_win[4:0], v_sample};
		end
	end
	if (y_valid) y_hold <= y_pair;
end

always_ff @(posedge Clock_50 or negedge Resetn) begin
	if (!Resetn) begin
		pair_valid <= 1'b0;
	end else begin
		pair_valid <= y_valid;
	end
end

always_comb begin
	pair.y_even = y_hold[1];
	pair.y_odd = y_hold[0];
	pair.u_even = u_win[3];
	pair.v_even = v_win[3];
	pair.u_odd = interpolate(u_win);
	pair.v_odd = interpolate(v_win);
end

endmodule

/* verilog/colour_matrix.sv */
`timescale 1ns/1ps

module colour_matrix (
	input  logic                 Clock_50,
	input  logic                 Resetn,
	input  logic                 pair_valid,
	input  csc_pkg::pixel_pair_t pair,
	output logic                 rgb_valid,
	output csc_pkg::rgb_pair_t   rgb
);

// products of one pixel, before summing
typedef struct packed {
	logic signed [31:0] y;
	logic signed [31:0] rv;
	logic signed [31:0] gu;
	logic signed [31:0] gv;
	logic signed [31:0] bu;
} terms_t;

terms_t even_q;
terms_t odd_q;
logic stage_valid;

function automatic terms_t products(
	input csc_pkg::sample_t y,
	input csc_pkg::sample_t u,
	input csc_pkg::sample_t v
);
	int ys;
	int us;
	int vs;
	ys = int'(y) - csc_pkg::y_offset;
	us = int'(u) - csc_pkg::c_offset;
	vs = int'(v) - csc_pkg::c_offset;
	products.y = csc_pkg::k_y * ys;
	products.rv = csc_pkg::k_rv * vs;
	products.gu = csc_pkg::k_gu * us;
	products.gv = csc_pkg::k_gv * vs;
	products.bu = csc_pkg::k_bu * us;
endfunction

function automatic csc_pkg::channel_t clip(input int sum);
	int scaled;
	scaled = sum >>> csc_pkg::mat_shift;
	if (scaled < 0) clip = 8'd0;
	else if (scaled > 255) clip = 8'd255;
	else clip = scaled[7:0];
endfunction

// r, g, b from high to low
function automatic csc_pkg::channel_t [2:0] pixel_rgb(input terms_t t);
	pixel_rgb[2] = clip(t.y + t.rv);
	pixel_rgb[1] = clip(t.y - t.gu - t.gv);
	pixel_rgb[0] = clip(t.y + t.bu);
endfunction

always_ff @(posedge Clock_50) begin
	if (pair_valid) begin
		even_q <= products(pair.y_even, pair.u_even, pair.v_even);
		odd_q <= products(pair.y_odd, pair.u_odd, pair.v_odd);
	end
	if (stage_valid) begin
		{rgb.r_even, rgb.g_even, rgb.b_even} <= pixel_rgb(even_q);
		{rgb.r_odd, rgb.g_odd, rgb.b_odd} <= pixel_rgb(odd_q);
	end
end

always_ff @(posedge Clock_50 or negedge Resetn) begin
	if (!Resetn) begin
		stage_valid <= 1'b0;
		rgb_valid <= 1'b0;
	end else begin
		stage_valid <= pair_valid;
		rgb_valid <= stage_valid;
	end
end

endmodule

/* verilog/csc_pkg.sv */
package csc_pkg;

	// bus and sample widths
	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;
	typedef logic [7:0] sample_t;
	typedef logic [7:0] channel_t;

	typedef struct packed {
		sram_addr_t address;
		sram_word_t write_data;
		logic       we_n;
	} sram_req_t;

	// one even/odd pixel pair, chroma already upsampled
	typedef struct packed {
		sample_t y_even;
		sample_t y_odd;
		sample_t u_even;
		sample_t v_even;
		sample_t u_odd;
		sample_t v_odd;
	} pixel_pair_t;

	typedef struct packed {
		channel_t r_even;
		channel_t g_even;
		channel_t b_even;
		channel_t r_odd;
		channel_t g_odd;
		channel_t b_odd;
	} rgb_pair_t;

	typedef enum logic [3:0] {
		seq_idle,
		seq_lead_in,
		seq_loop_0,
		seq_loop_1,
		seq_loop_2,
		seq_loop_3,
		seq_loop_4,
		seq_loop_5,
		seq_loop_6,
		seq_loop_7,
		seq_lead_out,
		seq_done
	} seq_state_t;

	// memory map
	localparam sram_addr_t y_base = 18'd0;
	localparam sram_addr_t u_base = 18'd38400;
	localparam sram_addr_t v_base = 18'd57600;
	localparam sram_addr_t rgb_base = 18'd146944;

	localparam int row_pixels = 320;
	localparam int row_pairs = row_pixels / 2;
	localparam int chroma_words = row_pairs / 2;
	localparam int rgb_words = 3 * row_pairs;
	localparam int sram_read_latency = 2;
	// chroma pushes needed before the window covers pair 0
	localparam int lead_in_pushes = 3;

	localparam int y_offset = 16;
	localparam int c_offset = 128;

	localparam int k_y = 76284;
	localparam int k_rv = 104595;
	localparam int k_gu = 25624;
	localparam int k_gv = 53281;
	localparam int k_bu = 132251;

	localparam int tap_outer = 21;
	localparam int tap_mid = 52;
	localparam int tap_inner = 159;

	localparam int fir_round = 128;
	localparam int fir_shift = 8;
	localparam int mat_shift = 16;

endpackage

/* verilog/sram_sequencer.sv */
`timescale 1ns/1ps

module sram_sequencer (
	input  logic                   Clock_50,
	input  logic                   Resetn,
	input  logic                   start,
	input  csc_pkg::sram_word_t    sram_read_data,
	input  logic                   rgb_valid,
	input  csc_pkg::rgb_pair_t     rgb,
	output csc_pkg::sram_req_t     sram_req,
	output logic                   chroma_push,
	output logic                   row_begin,
	output csc_pkg::sample_t       u_sample,
	output csc_pkg::sample_t       v_sample,
	output csc_pkg::sample_t [1:0] y_pair,
	output logic                   y_valid,
	output logic                   done
);

csc_pkg::seq_state_t state;
// loop pass count, the first passes only prime the chroma window
logic [7:0] iter;
logic byte_sel;
logic fetch_pair;
csc_pkg::sram_addr_t y_addr;
csc_pkg::sram_addr_t u_addr;
csc_pkg::sram_addr_t v_addr;
csc_pkg::sram_addr_t wr_addr;
logic [1:0] wr_left;
csc_pkg::sram_word_t y_word;
csc_pkg::sram_word_t u_word;
csc_pkg::sram_word_t v_word;
csc_pkg::sram_word_t wr_word;
csc_pkg::rgb_pair_t rgb_buf;
csc_pkg::sram_req_t req_next;
logic rd_y;
logic rd_u;
logic rd_v;
logic wr_now;

assign rd_y = (state == csc_pkg::seq_loop_0) && (iter >= 8'(csc_pkg::lead_in_pushes));
assign rd_u = (state == csc_pkg::seq_loop_1) && fetch_pair;
assign rd_v = (state == csc_pkg::seq_loop_2) && fetch_pair;
// writes take any cycle without a read
assign wr_now = (wr_left != 2'd0) && !(rd_y || rd_u || rd_v);

always_comb begin
	case (wr_left)
		2'd3: wr_word = {rgb_buf.r_even, rgb_buf.g_even};
		2'd2: wr_word = {rgb_buf.b_even, rgb_buf.r_odd};
		default: wr_word = {rgb_buf.g_odd, rgb_buf.b_odd};
	endcase
end

always_comb begin
	req_next.address = y_addr;
	req_next.write_data = wr_word;
	req_next.we_n = 1'b1;
	if (rd_u) begin
		req_next.address = u_addr;
	end else if (rd_v) begin
		req_next.address = v_addr;
	end else if (wr_now) begin
		req_next.address = wr_addr;
		req_next.we_n = 1'b0;
	end
end

always_ff @(posedge Clock_50 or negedge Resetn) begin
	if (!Resetn) begin
		state <= csc_pkg::seq_idle;
		sram_req <= '{address: '0, write_data: '0, we_n: 1'b1};
		iter <= '0;
		byte_sel <= 1'b0;
		fetch_pair <= 1'b0;
		y_addr <= csc_pkg::y_base;
		u_addr <= csc_pkg::u_base;
		v_addr <= csc_pkg::v_base;
		wr_addr <= csc_pkg::rgb_base;
		wr_left <= 2'd0;
		chroma_push <= 1'b0;
		row_begin <= 1'b0;
		y_valid <= 1'b0;
		done <= 1'b0;
	end else begin
		sram_req <= req_next;
		chroma_push <= 1'b0;
		row_begin <= 1'b0;
		y_valid <= 1'b0;
		if (rd_y) y_addr <= y_addr + 1'b1;
		if (rd_u) u_addr <= u_addr + 1'b1;
		if (rd_v) v_addr <= v_addr + 1'b1;
		if (wr_now) wr_addr <= wr_addr + 1'b1;
		if (rgb_valid) wr_left <= 2'd3;
		else if (wr_now) wr_left <= wr_left - 1'b1;
		case (state)
			csc_pkg::seq_idle, csc_pkg::seq_done: begin
				if (start) begin
					done <= 1'b0;
					state <= csc_pkg::seq_lead_in;
				end
			end
			csc_pkg::seq_lead_in: begin
				iter <= '0;
				byte_sel <= 1'b0;
				y_addr <= csc_pkg::y_base;
				u_addr <= csc_pkg::u_base;
				v_addr <= csc_pkg::v_base;
				wr_addr <= csc_pkg::rgb_base;
				state <= csc_pkg::seq_loop_0;
			end
			csc_pkg::seq_loop_0: begin
				// new chroma word on every other pass until the row runs out
				fetch_pair <= !byte_sel &&
					(u_addr != csc_pkg::sram_addr_t'(csc_pkg::u_base + csc_pkg::chroma_words));
				state <= csc_pkg::seq_loop_1;
			end
			csc_pkg::seq_loop_1: state <= csc_pkg::seq_loop_2;
			csc_pkg::seq_loop_2: state <= csc_pkg::seq_loop_3;
			csc_pkg::seq_loop_3: state <= csc_pkg::seq_loop_4;
			csc_pkg::seq_loop_4: state <= csc_pkg::seq_loop_5;
			csc_pkg::seq_loop_5: state <= csc_pkg::seq_loop_6;
			csc_pkg::seq_loop_6: begin
				chroma_push <= 1'b1;
				row_begin <= (iter == 8'd0);
				y_valid <= (iter >= 8'(csc_pkg::lead_in_pushes));
				byte_sel <= ~byte_sel;
				state <= csc_pkg::seq_loop_7;
			end
			csc_pkg::seq_loop_7: begin
				if (iter == 8'(csc_pkg::row_pairs + csc_pkg::lead_in_pushes - 1)) begin
					state <= csc_pkg::seq_lead_out;
				end else begin
					iter <= iter + 1'b1;
					state <= csc_pkg::seq_loop_0;
				end
			end
			csc_pkg::seq_lead_out: begin
				// wait for the last pair to drain through the matrix
				if (wr_addr == csc_pkg::sram_addr_t'(csc_pkg::rgb_base + csc_pkg::rgb_words)) begin
					done <= 1'b1;
					state <= csc_pkg::seq_done;
				end
			end
			default: state <= csc_pkg::seq_idle;
		endcase
	end
end

always_ff @(posedge Clock_50) begin
	if (state == csc_pkg::seq_loop_3) y_word <= sram_read_data;
	if (state == csc_pkg::seq_loop_4 && fetch_pair) u_word <= sram_read_data;
	if (state == csc_pkg::seq_loop_5 && fetch_pair) v_word <= sram_read_data;
	if (rgb_valid) rgb_buf <= rgb;
	if (state == csc_pkg::seq_loop_6) begin
		y_pair <= y_word;
		if (byte_sel) begin
			u_sample <= u_word[7:0];
			v_sample <= v_word[7:0];
		end else if (fetch_pair) begin
			u_sample <= u_word[15:8];
			v_sample <= v_word[15:8];
		end
		// past the row end the last sample is pushed again
	end
end

endmodule

/* verilog/yuv_to_rgb_top.sv */
`timescale 1ns/1ps

module yuv_to_rgb_top (
	input  logic                Clock_50,
	input  logic                Resetn,
	input  logic                start,
	input  csc_pkg::sram_word_t sram_read_data,
	output csc_pkg::sram_req_t  sram_req,
	output logic                done
);

logic chroma_push;
logic row_begin;
csc_pkg::sample_t u_sample;
csc_pkg::sample_t v_sample;
csc_pkg::sample_t [1:0] y_pair;
logic y_valid;
logic pair_valid;
csc_pkg::pixel_pair_t pair;
logic rgb_valid;
csc_pkg::rgb_pair_t rgb;

sram_sequencer u_sequencer (
	.Clock_50       (Clock_50),
	.Resetn         (Resetn),
	.start          (start),
	.sram_read_data (sram_read_data),
	.rgb_valid      (rgb_valid),
	.rgb            (rgb),
	.sram_req       (sram_req),
	.chroma_push    (chroma_push),
	.row_begin      (row_begin),
	.u_sample       (u_sample),
	.v_sample       (v_sample),
	.y_pair         (y_pair),
	.y_valid        (y_valid),
	.done           (done)
);

chroma_upsampler u_upsampler (
	.Clock_50    (Clock_50),
	.Resetn      (Resetn),
	.chroma_push (chroma_push),
	.row_begin   (row_begin),
	.u_sample    (u_sample),
	.v_sample    (v_sample),
	.y_pair      (y_pair),
	.y_valid     (y_valid),
	.pair_valid  (pair_valid),
	.pair        (pair)
);

colour_matrix u_matrix (
	.Clock_50   (Clock_50),
	.Resetn     (Resetn),
	.pair_valid (pair_valid),
	.pair       (pair),
	.rgb_valid  (rgb_valid),
	.rgb        (rgb)
);

endmodule
